/* verilog.f */
+incdir+include
src/cache_types_pkg.sv
src/cache_ctrl_if.sv
src/cache_way.sv
src/cache_datapath.sv
src/cache_control.sv
src/cache.sv
verif/cache_assert.sv
verif/cache_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then judge the simulation log
verilator --binary --timing --assert --top-module cache_tb -f verilog.f -o cache_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/cache_sim > sim.log 2>&1 || echo "simulator returned an error status" >> sim.log
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0

/* verif/cache_tb.sv */
`timescale 1ns/1ns

module cache_tb
    import cache_types_pkg::*;
();

    typedef logic [$bits(cache_addr_t)-$bits(cache_offset_t)-1:0] line_no_t;
    typedef logic [$bits(cache_offset_t)-2:0] word_sel_t;

    localparam int line_count    = 2 ** $bits(line_no_t);
    localparam int request_count = 232; // directed, random and flush requests.
    localparam int cycle_limit   = request_count * 12 + 16 + 200;

    logic        clk = 1'b0;
    logic        rst;
    cache_addr_t cpu_addr;
    logic        cpu_read;
    logic        cpu_write;
    cache_mask_t cpu_wmask;
    cache_word_t cpu_wdata;
    cache_word_t cpu_rdata;
    logic        cpu_resp;
    cache_addr_t mem_addr;
    logic        mem_read;
    logic        mem_write;
    cache_line_t mem_wdata;
    cache_line_t mem_rdata;
    logic        mem_resp;

    cache_line_t mem [line_count]; // backing memory, one entry per line.
    logic [15:0] mem_lfsr;
    logic        mem_busy;
    int          mem_wait;
    int          mem_reads;
    int          mem_writes;
    cache_addr_t fill_addr;
    cache_addr_t wb_addr;
    cache_line_t wb_line;

    // memory as the cpu sees it, and the expected tags, dirty bits and lru.
    cache_word_t shadow [line_count * 8];
    logic        model_valid [8][2];
    logic        model_dirty [8][2];
    cache_tag_t  model_tag   [8][2];
    logic        model_lru   [8];
    logic [15:0] stim_lfsr;

    int checks;
    int errors;
    int cycles = 0;

    cache u_dut (
        .clk       (clk),
        .rst       (rst),
        .cpu_addr  (cpu_addr),
        .cpu_read  (cpu_read),
        .cpu_write (cpu_write),
        .cpu_wmask (cpu_wmask),
        .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata),
        .cpu_resp  (cpu_resp),
        .mem_addr  (mem_addr),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_resp  (mem_resp)
    );

    always #4 clk = ~clk;

    // galois lfsr, one step per bit taken.
    function automatic logic [31:0] take_bits(inout logic [15:0] state, input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], state[0]};
            state = (state >> 1) ^ (state[0] ? 16'hb400 : 16'h0000);
        end
        return value;
    endfunction

    function automatic line_no_t line_of(cache_addr_t addr);
        return addr[$bits(cache_addr_t)-1:$bits(cache_offset_t)];
    endfunction

    function automatic cache_addr_t make_addr(int tag, int set, int word);
        return {cache_tag_t'(tag), cache_index_t'(set), word_sel_t'(word), 1'b0};
    endfunction

    function automatic cache_line_t shadow_line(line_no_t ln);
        cache_line_t l;
        l = '0;
        for (int w = 0; w < 8; w++) begin
            l = {shadow[{ln, word_sel_t'(w)}], l[127:16]}; // word 0 ends lowest.
        end
        return l;
    endfunction

    task automatic check_word(input string name, input cache_word_t expected,
                              input cache_word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: word expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_line(input string name, input cache_line_t expected,
                              input cache_line_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: line expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_addr(input string name, input cache_addr_t expected,
                              input cache_addr_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: address expected %h, actual %h", name, expected, actual);
        end
    endtask

    // one cpu request, predicted from the tag model and checked against the shadow.
    task automatic access(input string name, input cache_addr_t addr, input logic write,
                          input cache_mask_t mask, input cache_word_t data);
        cache_tag_t    tag;
        cache_index_t  set;
        cache_offset_t offset;
        word_sel_t     ws;
        logic          way;
        logic          miss;
        logic          evict;
        cache_addr_t   exp_wb_addr;
        cache_line_t   exp_wb_line;
        int            reads_before;
        int            writes_before;
        cache_word_t   old_word;
        cache_word_t   got;
        {tag, set, offset} = addr;
        ws    = offset[$bits(cache_offset_t)-1:1];
        miss  = 1'b0;
        evict = 1'b0;
        if (model_valid[set][0] && model_tag[set][0] == tag) begin
            way = 1'b0;
        end else if (model_valid[set][1] && model_tag[set][1] == tag) begin
            way = 1'b1;
        end else begin
            miss  = 1'b1;
            way   = model_lru[set]; // victim is the lru way.
            evict = model_valid[set][way] && model_dirty[set][way];
            exp_wb_addr = {model_tag[set][way], set, cache_offset_t'(0)};
            exp_wb_line = shadow_line(line_of(exp_wb_addr));
            model_valid[set][way] = 1'b1;
            model_tag[set][way]   = tag;
            model_dirty[set][way] = 1'b0;
        end
        model_lru[set] = ~way;
        if (write) model_dirty[set][way] = 1'b1;

        reads_before  = mem_reads;
        writes_before = mem_writes;
        @(posedge clk);
        cpu_addr  <= addr;
        cpu_read  <= ~write;
        cpu_write <= write;
        cpu_wmask <= mask;
        cpu_wdata <= data;
        do begin
            @(negedge clk);
        end while (!cpu_resp);
        got = cpu_rdata;
        @(posedge clk);
        cpu_read  <= 1'b0;
        cpu_write <= 1'b0;

        checks++;
        if (mem_reads - reads_before != int'(miss) ||
            mem_writes - writes_before != int'(evict)) begin
            errors++;
            $display("FAIL %s: memory reads/writes expected %0d/%0d, actual %0d/%0d", name,
                     int'(miss), int'(evict), mem_reads - reads_before,
                     mem_writes - writes_before);
        end
        if (evict) begin
            check_addr(name, exp_wb_addr, wb_addr);
            check_line(name, exp_wb_line, wb_line);
        end
        if (miss) check_addr(name, {tag, set, cache_offset_t'(0)}, fill_addr);
        old_word = shadow[{line_of(addr), ws}];
        if (write) begin
            shadow[{line_of(addr), ws}] = {mask[1] ? data[15:8] : old_word[15:8],
                                           mask[0] ? data[7:0] : old_word[7:0]};
        end else begin
            check_word(name, old_word, got);
        end
    endtask

    task automatic read_miss_fill();
        access("read_miss_fill", make_addr(5, 2, 3), 1'b0, 2'b00, 16'h0000);
        access("read_miss_fill", make_addr(5, 2, 6), 1'b0, 2'b00, 16'h0000); // same line.
    endtask

    task automatic write_hit_merge();
        access("write_hit_merge", make_addr(5, 2, 3), 1'b1, 2'b01, 16'ha5a5);
        access("write_hit_merge", make_addr(5, 2, 3), 1'b1, 2'b10, 16'h3c3c);
        access("write_hit_merge", make_addr(5, 2, 0), 1'b1, 2'b11, 16'h1234);
        access("write_hit_merge", make_addr(5, 2, 3), 1'b0, 2'b00, 16'h0000);
        access("write_hit_merge", make_addr(5, 2, 0), 1'b0, 2'b00, 16'h0000);
    endtask

    task automatic dirty_eviction();
        access("dirty_eviction", make_addr(7, 4, 1), 1'b1, 2'b11, 16'hbeef);
        access("dirty_eviction", make_addr(8, 4, 2), 1'b0, 2'b00, 16'h0000);
        access("dirty_eviction", make_addr(9, 4, 5), 1'b0, 2'b00, 16'h0000); // evicts tag 7.
    endtask

    task automatic lru_replacement();
        access("lru_replacement", make_addr(1, 6, 0), 1'b0, 2'b00, 16'h0000);
        access("lru_replacement", make_addr(2, 6, 0), 1'b0, 2'b00, 16'h0000);
        access("lru_replacement", make_addr(1, 6, 1), 1'b0, 2'b00, 16'h0000);
        access("lru_replacement", make_addr(3, 6, 0), 1'b0, 2'b00, 16'h0000);
        access("lru_replacement", make_addr(1, 6, 2), 1'b0, 2'b00, 16'h0000); // still a hit
        access("lru_replacement", make_addr(2, 6, 0), 1'b0, 2'b00, 16'h0000);
    endtask

    task automatic random_traffic();
        logic [31:0] bits;
        logic [4:0]  line;
        int          word;
        logic        write;
        cache_mask_t mask;
        cache_word_t data;
        for (int n = 0; n < 200; n++) begin
            bits  = take_bits(stim_lfsr, 5);
            line  = bits[4:0];
            bits  = take_bits(stim_lfsr, 3);
            word  = int'(bits[2:0]);
            bits  = take_bits(stim_lfsr, 1);
            write = bits[0];
            bits  = take_bits(stim_lfsr, 2);
            mask  = bits[1:0];
            bits  = take_bits(stim_lfsr, 16);
            data  = bits[15:0];
            // four tags on each of the eight sets.
            access("random_traffic", make_addr(16 + int'(line[4:3]), int'(line[2:0]), word),
                   write, mask, data);
        end
        for (int s = 0; s < 8; s++) begin
            access("random_traffic", make_addr(400, s, 0), 1'b0, 2'b00, 16'h0000);
            access("random_traffic", make_addr(401, s, 0), 1'b0, 2'b00, 16'h0000);
        end
        for (int i = 0; i < line_count; i++) begin
            check_line("random_traffic", shadow_line(line_no_t'(i)), mem[line_no_t'(i)]);
        end
    endtask

    // memory model, answers each strobe after one to four cycles.
    initial begin
        cache_line_t l;
        l          = '0;
        mem_lfsr   = 16'h0001;
        mem_resp   = 1'b0;
        mem_rdata  = '0;
        mem_busy   = 1'b0;
        mem_wait   = 0;
        mem_reads  = 0;
        mem_writes = 0;
        for (int i = 0; i < line_count; i++) begin
            for (int k = 0; k < 4; k++) begin
                l = {l[95:0], take_bits(mem_lfsr, 32)};
            end
            mem[line_no_t'(i)] = l;
        end
        forever begin
            @(posedge clk);
            if (rst) begin
                mem_resp <= 1'b0;
                mem_busy = 1'b0;
            end else if (mem_resp) begin
                mem_resp <= 1'b0;
            end else if (mem_read || mem_write) begin
                if (!mem_busy) begin
                    mem_busy = 1'b1;
                    mem_wait = int'(take_bits(mem_lfsr, 2));
                end else begin
                    mem_wait--;
                end
                if (mem_wait == 0) begin
                    mem_busy = 1'b0;
                    mem_resp <= 1'b1;
                    if (mem_write) begin
                        mem[line_of(mem_addr)] = mem_wdata;
                        wb_addr = mem_addr;
                        wb_line = mem_wdata;
                        mem_writes++;
                    end else begin
                        mem_rdata <= mem[line_of(mem_addr)];
                        fill_addr = mem_addr;
                        mem_reads++;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            $display("ERROR: run did not finish within %0d cycles, a request is stuck",
                     cycle_limit);
            $display("checks: %0d, errors: %0d", checks, errors + 1);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        cache_line_t l;
        rst         = 1'b1;
        cpu_addr    = '0;
        cpu_read    = 1'b0;
        cpu_write   = 1'b0;
        cpu_wmask   = '0;
        cpu_wdata   = '0;
        stim_lfsr   = 16'h0001;
        checks      = 0;
        errors      = 0;
        model_valid = '{default: '0};
        model_dirty = '{default: '0};
        model_lru   = '{default: '0};
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < line_count; i++) begin
            l = mem[line_no_t'(i)];
            for (int w = 0; w < 8; w++) begin
                shadow[{line_no_t'(i), word_sel_t'(w)}] = l[15:0];
                l = l >> 16;
            end
        end

        read_miss_fill();
        write_hit_merge();
        dirty_eviction();
        lru_replacement();
        random_traffic();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verif/cache_assert.sv */
`timescale 1ns/1ns

module cache_assert
    import cache_types_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input logic         cpu_read,
    input logic         cpu_write,
    input logic         cpu_resp,
    input logic         mem_read,
    input logic         mem_write,
    input logic         mem_resp,
    input cache_state_t state
);

    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write are high together");

    // a response only answers a pending request.
    a_resp_with_req: assert property (@(posedge clk) disable iff (rst)
        cpu_resp |-> (cpu_read || cpu_write))
        else $error("cpu_resp without a cpu request");

    a_read_held: assert property (@(posedge clk) disable iff (rst)
        (mem_read && !mem_resp) |=> mem_read)
        else $error("mem_read dropped before mem_resp");

    a_write_held: assert property (@(posedge clk) disable iff (rst)
        (mem_write && !mem_resp) |=> mem_write)
        else $error("mem_write dropped before mem_resp");

    a_reset_idle: assert property (@(posedge clk) rst |=> (state == idle_hit))
        else $error("controller not idle after reset");

endmodule

bind cache_control cache_assert u_assert (
    .clk       (clk),
    .rst       (rst),
    .cpu_read  (cpu_read),
    .cpu_write (cpu_write),
    .cpu_resp  (cpu_resp),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_resp  (mem_resp),
    .state     (state)
);

/* src/cache.sv */
`timescale 1ns/1ns

module cache
    import cache_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // cpu side.
    input  cache_addr_t cpu_addr,
    input  logic        cpu_read,
    input  logic        cpu_write,
    input  cache_mask_t cpu_wmask,
    input  cache_word_t cpu_wdata,
    output cache_word_t cpu_rdata,
    output logic        cpu_resp,
    // memory side, one line per transfer.
    output cache_addr_t mem_addr,
    output logic        mem_read,
    output logic        mem_write,
    output cache_line_t mem_wdata,
    input  cache_line_t mem_rdata,
    input  logic        mem_resp
);

    cache_ctrl_if ctrl_if ();

    cache_datapath u_datapath (
        .clk       (clk),
        .rst       (rst),
        .cpu_addr  (cpu_addr),
        .cpu_wmask (cpu_wmask),
        .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .ctrl      (ctrl_if.datapath)
    );

    cache_control u_control (
        .clk       (clk),
        .rst       (rst),
        .cpu_read  (cpu_read),
        .cpu_write (cpu_write),
        .mem_resp  (mem_resp),
        .cpu_resp  (cpu_resp),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .ctrl      (ctrl_if.control)
    );

endmodule

/* src/cache_control.sv */
`timescale 1ns/1ns

module cache_control
    import cache_types_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic cpu_read,
    input  logic cpu_write,
    input  logic mem_resp,
    output logic cpu_resp,
    output logic mem_read,
    output logic mem_write,
    cache_ctrl_if.control ctrl
);

    cache_state_t state;
    cache_state_t next_state;
    logic         cpu_req;

    assign cpu_req = cpu_read | cpu_write;

    // outputs per state, mealy only in idle_hit.
    always_comb begin
        ctrl.cacheline_sel  = 1'b0;
        ctrl.tag_source_sel = 1'b0;
        ctrl.load           = 1'b0;
        ctrl.load_all       = 1'b0;
        ctrl.load_lru       = 1'b0;
        ctrl.lru_in         = 1'b0;
        cpu_resp            = 1'b0;
        mem_read            = 1'b0;
        mem_write           = 1'b0;

        case (state)
            idle_hit: begin
                if (cpu_req && ctrl.hit_any) begin
                    // the other way becomes least recently used.
                    ctrl.cacheline_sel = ctrl.hit_1;
                    ctrl.lru_in        = ~ctrl.hit_1;
                    ctrl.load_lru      = 1'b1;
                    ctrl.load          = cpu_write; // merge only on a write.
                    cpu_resp           = 1'b1;
                end
            end

            write_back: begin
                ctrl.cacheline_sel = ctrl.lru_out;
                mem_write          = 1'b1; // address from the stored tag.
            end

            read_in: begin
                ctrl.cacheline_sel  = ctrl.lru_out;
                ctrl.tag_source_sel = 1'b1;
                ctrl.load_all       = 1'b1; // last write lands with mem_resp.
                mem_read            = 1'b1;
            end

            default: begin
            end
        endcase
    end

    always_comb begin
        next_state = state;

        case (state)
            idle_hit: begin
                if (cpu_req && !ctrl.hit_any) begin
                    next_state = ctrl.dirty_out ? write_back : read_in;
                end
            end

            write_back: begin
                if (mem_resp) next_state = read_in;
            end

            read_in: begin
                if (mem_resp) next_state = idle_hit; // request then hits.
            end

            default: next_state = idle_hit;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle_hit;
        end else begin
            state <= next_state;
        end
    end

endmodule

/* src/cache_datapath.sv */
`timescale 1ns/1ns

module cache_datapath
    import cache_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  cache_addr_t cpu_addr,
    input  cache_mask_t cpu_wmask,
    input  cache_word_t cpu_wdata,
    output cache_word_t cpu_rdata,
    input  cache_line_t mem_rdata,
    output cache_addr_t mem_addr,
    output cache_line_t mem_wdata,
    cache_ctrl_if.datapath ctrl
);

    localparam int SETS     = 2 ** $bits(cache_index_t);
    localparam int WORD_W   = $bits(cache_word_t);
    localparam int BYTES    = WORD_W / 8;
    localparam int WORDS    = $bits(cache_line_t) / WORD_W;
    localparam int SEL_W    = $clog2(WORDS);
    localparam int BYTE_LSB = $clog2(BYTES);

    cache_tag_t    tag;
    cache_index_t  index;
    cache_offset_t offset;
    logic [SEL_W-1:0] word_sel;

    logic        way_valid [2];
    logic        way_dirty [2];
    cache_tag_t  way_tag   [2];
    cache_line_t way_line  [2];
    logic        way_write [2];

    logic [SETS-1:0] lru_bits;
    cache_line_t sel_line;
    cache_line_t hit_line;
    cache_line_t merged_line;
    cache_line_t fill_line;
    cache_word_t old_word;
    cache_word_t new_word;
    cache_tag_t  mem_tag;

    assign {tag, index, offset} = cpu_addr;
    assign word_sel = offset[$bits(cache_offset_t)-1:BYTE_LSB];

    // both ways get the same line and tag, only the write enable differs.
    for (genvar w = 0; w < 2; w++) begin : g_way
        assign way_write[w] = (ctrl.load | ctrl.load_all) && (ctrl.cacheline_sel == w[0]);

        cache_way u_way (
            .clk      (clk),
            .rst      (rst),
            .index    (index),
            .tag_in   (tag),
            .line_in  (fill_line),
            .write    (way_write[w]),
            .dirty_in (~ctrl.load_all),
            .valid    (way_valid[w]),
            .dirty    (way_dirty[w]),
            .tag      (way_tag[w]),
            .line     (way_line[w])
        );
    end

    assign ctrl.hit_0   = way_valid[0] && (way_tag[0] == tag);
    assign ctrl.hit_1   = way_valid[1] && (way_tag[1] == tag);
    assign ctrl.hit_any = ctrl.hit_0 | ctrl.hit_1;

    // one lru bit per set, names the way to evict next.
    always_ff @(posedge clk) begin
        if (rst) begin
            lru_bits <= '0;
        end else if (ctrl.load_lru) begin
            lru_bits[index] <= ctrl.lru_in;
        end
    end

    assign ctrl.lru_out   = lru_bits[index];
    assign ctrl.dirty_out = way_dirty[ctrl.lru_out];

    assign sel_line = way_line[ctrl.cacheline_sel];
    assign hit_line = ctrl.hit_1 ? way_line[1] : way_line[0];
    assign old_word = sel_line[word_sel*WORD_W +: WORD_W];

    // byte merge of the cpu word into the selected line.
    always_comb begin
        for (int b = 0; b < BYTES; b++) begin
            new_word[b*8 +: 8] = cpu_wmask[b] ? cpu_wdata[b*8 +: 8] : old_word[b*8 +: 8];
        end
        merged_line = sel_line;
        merged_line[word_sel*WORD_W +: WORD_W] = new_word;
    end

    assign fill_line = ctrl.load_all ? mem_rdata : merged_line;
    assign cpu_rdata = hit_line[word_sel*WORD_W +: WORD_W];

    // old tag for write back, cpu tag for a fill.
    assign mem_tag   = ctrl.tag_source_sel ? tag : way_tag[ctrl.cacheline_sel];
    assign mem_addr  = {mem_tag, index, cache_offset_t'(0)};
    assign mem_wdata = sel_line;

endmodule

/* src/cache_way.sv */
`timescale 1ns/1ns

module cache_way
    import cache_types_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  cache_index_t index,
    input  cache_tag_t   tag_in,
    input  cache_line_t  line_in,
    input  logic         write,
    input  logic         dirty_in,
    output logic         valid,
    output logic         dirty,
    output cache_tag_t   tag,
    output cache_line_t  line
);

    localparam int SETS = 2 ** $bits(cache_index_t);

    logic [SETS-1:0] valid_bits;
    logic [SETS-1:0] dirty_bits;
    cache_tag_t      tags  [SETS];
    cache_line_t     lines [SETS];

    // per set status bits.
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (write) begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= dirty_in; // set on cpu write, cleared on fill.
        end
    end

    // tag and data storage.
    always_ff @(posedge clk) begin
        if (write) begin
            tags[index]  <= tag_in;
            lines[index] <= line_in;
        end
    end

    // lookup is combinational from the index.
    assign valid = valid_bits[index];
    assign dirty = dirty_bits[index];
    assign tag   = tags[index];
    assign line  = lines[index];

endmodule

/* src/cache_ctrl_if.sv */
`timescale 1ns/1ns

interface cache_ctrl_if;

    // status, combinational from the addressed set.
    logic hit_0;
    logic hit_1;
    logic hit_any;
    logic dirty_out; // dirty bit of the lru way.
    logic lru_out;   // which way is least recently used.

    // control from the sequencer.
    logic cacheline_sel;  // way used for writes and memory data.
    logic tag_source_sel; // 0 stored tag, 1 cpu tag.
    logic load;           // merge cpu word into the line.
    logic load_all;       // take the whole line from memory.
    logic load_lru;
    logic lru_in;

    modport datapath (
        output hit_0, hit_1, hit_any, dirty_out, lru_out,
        input  cacheline_sel, tag_source_sel, load, load_all, load_lru, lru_in
    );

    modport control (
        input  hit_0, hit_1, hit_any, dirty_out, lru_out,
        output cacheline_sel, tag_source_sel, load, load_all, load_lru, lru_in
    );

endinterface

/* src/cache_types_pkg.sv */
package cache_types_pkg;

`include "cache_settings.svh"

    typedef logic [`CACHE_ADDR_WIDTH-1:0] cache_addr_t;
    typedef logic [`CACHE_WORD_WIDTH-1:0] cache_word_t;
    typedef logic [`CACHE_LINE_WIDTH-1:0] cache_line_t;

    // address fields, tag is the upper remainder.
    typedef logic [`CACHE_ADDR_WIDTH-`CACHE_INDEX_BITS-`CACHE_OFFSET_BITS-1:0] cache_tag_t;
    typedef logic [`CACHE_INDEX_BITS-1:0] cache_index_t;
    typedef logic [`CACHE_OFFSET_BITS-1:0] cache_offset_t; // upper bits pick the word.

    typedef logic [`CACHE_WORD_WIDTH/8-1:0] cache_mask_t; // one enable per byte.

    // controller sequence for hit service, eviction and fill.
    typedef enum logic [1:0] {
        idle_hit,
        write_back,
        read_in
    } cache_state_t;

endpackage

/* include/cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// byte address seen by the CPU and by memory.
`define CACHE_ADDR_WIDTH 16

// one CPU word, two bytes.
`define CACHE_WORD_WIDTH 16

// address split, the tag takes what is left over.
`define CACHE_OFFSET_BITS 4
`define CACHE_INDEX_BITS 3

`define CACHE_LINE_WIDTH 128 // eight words per line.

`endif
